// ==== qaz_pkg.sv ====
// ----------------------------------------------------------
// QAZ bus core shared definitions
// Bus types, slave address map and register offsets
// ----------------------------------------------------------
`default_nettype none

package qaz_pkg;

  // ----------------------------------------------------------
  // Bus types
  typedef logic [23:0] addr_t;     // Host byte address
  typedef logic [31:0] data_t;     // Bus data word
  typedef logic [1:0]  reg_off_t;  // Word offset, address bits 3:2
  typedef logic [6:0]  seg_t;      // One seven-segment digit

  // ----------------------------------------------------------
  // Slave select, address bits 23:20
  localparam logic [3:0] SLV_GPIO_A = 4'd1;  // Display digits and keys
  localparam logic [3:0] SLV_GPIO_B = 4'd2;  // LEDs and switches
  localparam logic [3:0] SLV_SYSCTL = 4'd3;
  localparam logic [3:0] SLV_PIC    = 4'd4;

  // GPIO registers
  localparam reg_off_t GPIO_OUT = 2'd0;  // Output pins, rw
  localparam reg_off_t GPIO_IN  = 2'd1;  // Synced inputs, ro
  localparam reg_off_t GPIO_IE  = 2'd2;  // Irq enable, rw
  localparam reg_off_t GPIO_IS  = 2'd3;  // Irq status, write 1 clears

  // PIC registers
  localparam reg_off_t PIC_PEND = 2'd0;  // Raw sources, ro
  localparam reg_off_t PIC_MASK = 2'd1;

  // System control registers
  localparam reg_off_t SYS_ID      = 2'd0;
  localparam reg_off_t SYS_SCRATCH = 2'd1;
  localparam reg_off_t SYS_CYCLES  = 2'd2;

  localparam data_t SYS_ID_VALUE = 32'h5141_5a01;  // "QAZ", rev 1
  localparam int    IRQ_N        = 2;              // Interrupt sources

endpackage

`default_nettype wire

// ==== wb_slave_decode.sv ====
// ----------------------------------------------------------
// Host port address decoder
// Slave strobe select, response mux, err for unmapped space
// ----------------------------------------------------------
`default_nettype none

module wb_slave_decode (
  input  logic                    sys_clk,
  input  logic                    sys_rst,
  // Host side
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  qaz_pkg::addr_t          wb_adr_i,
  output qaz_pkg::data_t          wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  // Slave side, indexed by select value
  input  qaz_pkg::data_t [4:1]    s_dat_i,
  input  logic [4:1]              s_ack_i,
  output logic [4:1]              s_stb_o
);
  import qaz_pkg::*;

  logic [3:0] sel;       // Slave select field
  logic       bus_req;   // Host strobe inside a cycle
  logic       mapped;
  logic       err_q;

  assign sel     = wb_adr_i[23:20];
  assign bus_req = wb_cyc_i & wb_stb_i;
  assign mapped  = (sel == SLV_GPIO_A) || (sel == SLV_GPIO_B) ||
                   (sel == SLV_SYSCTL) || (sel == SLV_PIC);

  // ----------------------------------------------------------
  // Strobe goes to the selected slave only
  assign s_stb_o[SLV_GPIO_A] = bus_req && (sel == SLV_GPIO_A);
  assign s_stb_o[SLV_GPIO_B] = bus_req && (sel == SLV_GPIO_B);
  assign s_stb_o[SLV_SYSCTL] = bus_req && (sel == SLV_SYSCTL);
  assign s_stb_o[SLV_PIC]    = bus_req && (sel == SLV_PIC);

  // ----------------------------------------------------------
  // Response mux, address is held until ack
  always_comb
  begin
    case (sel)
      SLV_GPIO_A: wb_dat_o = s_dat_i[SLV_GPIO_A];
      SLV_GPIO_B: wb_dat_o = s_dat_i[SLV_GPIO_B];
      SLV_SYSCTL: wb_dat_o = s_dat_i[SLV_SYSCTL];
      SLV_PIC:    wb_dat_o = s_dat_i[SLV_PIC];
      default:    wb_dat_o = '0;  // Unmapped reads zero
    endcase
  end

  assign wb_ack_o = |(s_ack_i & s_stb_o);  // Only the selected slave counts

  // Unmapped access gets one cycle of err, same schedule as a slave ack
  always_ff @(posedge sys_clk or posedge sys_rst)
  begin
    if (sys_rst)
      err_q <= 1'b0;
    else
      err_q <= bus_req & ~mapped & ~err_q;
  end

  assign wb_err_o = err_q;

endmodule

`default_nettype wire

// ==== gpio_port.sv ====
// ----------------------------------------------------------
// GPIO slave
// Output register, synced inputs, rising-edge irq status
// ----------------------------------------------------------
`default_nettype none

module gpio_port #(
  parameter int unsigned OUT_W = 32,
  parameter int unsigned IN_W  = 32
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  qaz_pkg::reg_off_t    off_i,
  input  qaz_pkg::data_t       dat_i,
  input  logic [IN_W-1:0]      pin_i,
  output qaz_pkg::data_t       dat_o,
  output logic                 ack_o,
  output logic [OUT_W-1:0]     pin_o,
  output logic                 irq_o
);
  import qaz_pkg::*;

  logic             ack_q;
  logic             wr;        // Write strobe at the ack edge
  logic [OUT_W-1:0] out_q;
  logic [IN_W-1:0]  ie_q;
  logic [IN_W-1:0]  is_q;
  logic [IN_W-1:0]  sync_q1;   // Input synchronizer
  logic [IN_W-1:0]  sync_q2;
  logic [IN_W-1:0]  prev_q;    // Last synced value, for edge detect
  logic [IN_W-1:0]  rise;
  logic [IN_W-1:0]  clr;

  assign wr   = stb_i & ~ack_q & we_i;
  assign rise = sync_q2 & ~prev_q;
  assign clr  = (wr && off_i == GPIO_IS) ? dat_i[IN_W-1:0] : '0;

  // ----------------------------------------------------------
  // Handshake and registers
  always_ff @(posedge sys_clk or posedge sys_rst)
  begin
    if (sys_rst)
    begin
      ack_q   <= 1'b0;
      out_q   <= '0;
      ie_q    <= '0;
      is_q    <= '0;
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
    end
    else
    begin
      ack_q   <= stb_i & ~ack_q;  // One cycle per strobe
      sync_q1 <= pin_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
      if (wr && off_i == GPIO_OUT)
        out_q <= dat_i[OUT_W-1:0];
      if (wr && off_i == GPIO_IE)
        ie_q <= dat_i[IN_W-1:0];
      is_q <= (is_q & ~clr) | rise;  // Edge beats clear
    end
  end

  // Read mux, upper bits zero
  always_comb
  begin
    case (off_i)
      GPIO_OUT: dat_o = data_t'(out_q);
      GPIO_IN:  dat_o = data_t'(sync_q2);
      GPIO_IE:  dat_o = data_t'(ie_q);
      GPIO_IS:  dat_o = data_t'(is_q);
      default:  dat_o = '0;
    endcase
  end

  assign ack_o = ack_q;
  assign pin_o = out_q;
  assign irq_o = |(is_q & ie_q);  // Enabled status only

endmodule

`default_nettype wire

// ==== qaz_pic.sv ====
// ----------------------------------------------------------
// Simple interrupt controller
// Level sources, mask register, one combined output
// ----------------------------------------------------------
`default_nettype none

module qaz_pic (
  input  logic                        sys_clk,
  input  logic                        sys_rst,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  qaz_pkg::reg_off_t           off_i,
  input  qaz_pkg::data_t              dat_i,
  input  logic [qaz_pkg::IRQ_N-1:0]   irq_i,
  output qaz_pkg::data_t              dat_o,
  output logic                        ack_o,
  output logic                        int_o
);
  import qaz_pkg::*;

  logic             ack_q;
  logic [IRQ_N-1:0] mask_q;  // 1 lets the source through

  always_ff @(posedge sys_clk or posedge sys_rst)
  begin
    if (sys_rst)
    begin
      ack_q  <= 1'b0;
      mask_q <= '0;
    end
    else
    begin
      ack_q <= stb_i & ~ack_q;
      if (stb_i && !ack_q && we_i && off_i == PIC_MASK)
        mask_q <= dat_i[IRQ_N-1:0];
    end
  end

  // Pending is the raw level of each source
  always_comb
  begin
    case (off_i)
      PIC_PEND: dat_o = data_t'(irq_i);
      PIC_MASK: dat_o = data_t'(mask_q);
      default:  dat_o = '0;
    endcase
  end

  assign ack_o = ack_q;
  assign int_o = |(irq_i & mask_q);  // No register stage

endmodule

`default_nettype wire

// ==== qaz_sysctl.sv ====
// ----------------------------------------------------------
// System control slave
// ID word, scratch register, cycle counter and heartbeat
// ----------------------------------------------------------
`default_nettype none

module qaz_sysctl #(
  parameter int unsigned HB_BIT = 24  // Counter bit for the heartbeat
) (
  input  logic                sys_clk,
  input  logic                sys_rst,
  input  logic                stb_i,
  input  logic                we_i,
  input  qaz_pkg::reg_off_t   off_i,
  input  qaz_pkg::data_t      dat_i,
  output qaz_pkg::data_t      dat_o,
  output logic                ack_o,
  output logic                heartbeat_o
);
  import qaz_pkg::*;

  logic  ack_q;
  data_t scratch_q;
  data_t cnt_q;  // Free running since reset

  // ----------------------------------------------------------
  // Registers
  always_ff @(posedge sys_clk or posedge sys_rst)
  begin
    if (sys_rst)
    begin
      ack_q     <= 1'b0;
      scratch_q <= '0;
      cnt_q     <= '0;
    end
    else
    begin
      ack_q <= stb_i & ~ack_q;
      cnt_q <= cnt_q + 32'd1;
      // Only scratch is writable, others ack and drop the data
      if (stb_i && !ack_q && we_i && off_i == SYS_SCRATCH)
        scratch_q <= dat_i;
    end
  end

  // Read mux, counter value matches the heartbeat in the same cycle
  always_comb
  begin
    case (off_i)
      SYS_ID:      dat_o = SYS_ID_VALUE;
      SYS_SCRATCH: dat_o = scratch_q;
      SYS_CYCLES:  dat_o = cnt_q;
      default:     dat_o = '0;
    endcase
  end

  assign ack_o       = ack_q;
  assign heartbeat_o = cnt_q[HB_BIT];

endmodule

`default_nettype wire

// ==== qaz_top.sv ====
// ----------------------------------------------------------
// QAZ bus core top level
// Host port, decoder, two GPIO ports, PIC and system control
// ----------------------------------------------------------
`default_nettype none

module qaz_top #(
  parameter int unsigned HB_BIT = 24
) (
  input  logic              sys_clk,
  input  logic              sys_rst,
  // Host port
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  qaz_pkg::addr_t    wb_adr_i,
  input  qaz_pkg::data_t    wb_dat_i,
  output qaz_pkg::data_t    wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  // Board pins
  input  logic [3:0]        key_i,
  input  logic [9:0]        sw_i,
  output qaz_pkg::seg_t     hex0_o,
  output qaz_pkg::seg_t     hex1_o,
  output qaz_pkg::seg_t     hex2_o,
  output qaz_pkg::seg_t     hex3_o,
  output logic [7:0]        ledg_o,
  output logic [9:0]        ledr_o,
  output logic              int_o,
  output logic              heartbeat_o
);
  import qaz_pkg::*;

  data_t [4:1]      s_dat;   // Slave read data by select value
  logic  [4:1]      s_ack;
  logic  [4:1]      s_stb;
  logic  [27:0]     disp_pins;
  logic  [17:0]     led_pins;
  logic  [IRQ_N-1:0] irq;

  // ----------------------------------------------------------
  // Host side decode
  wb_slave_decode u_decode (
    .sys_clk (sys_clk),  .sys_rst (sys_rst),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_adr_i(wb_adr_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
    .s_dat_i (s_dat),    .s_ack_i (s_ack),    .s_stb_o (s_stb)
  );

  // Display digits out, keys in
  gpio_port #(.OUT_W(28), .IN_W(4)) u_gpio_disp (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .stb_i(s_stb[SLV_GPIO_A]),
    .we_i(wb_we_i), .off_i(wb_adr_i[3:2]), .dat_i(wb_dat_i), .pin_i(key_i),
    .dat_o(s_dat[SLV_GPIO_A]), .ack_o(s_ack[SLV_GPIO_A]),
    .pin_o(disp_pins), .irq_o(irq[1])
  );

  // LEDs out, switches in
  gpio_port #(.OUT_W(18), .IN_W(10)) u_gpio_led (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .stb_i(s_stb[SLV_GPIO_B]),
    .we_i(wb_we_i), .off_i(wb_adr_i[3:2]), .dat_i(wb_dat_i), .pin_i(sw_i),
    .dat_o(s_dat[SLV_GPIO_B]), .ack_o(s_ack[SLV_GPIO_B]),
    .pin_o(led_pins), .irq_o(irq[0])
  );

  qaz_pic u_pic (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .stb_i(s_stb[SLV_PIC]),
    .we_i(wb_we_i), .off_i(wb_adr_i[3:2]), .dat_i(wb_dat_i), .irq_i(irq),
    .dat_o(s_dat[SLV_PIC]), .ack_o(s_ack[SLV_PIC]), .int_o(int_o)
  );

  qaz_sysctl #(.HB_BIT(HB_BIT)) u_sysctl (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .stb_i(s_stb[SLV_SYSCTL]),
    .we_i(wb_we_i), .off_i(wb_adr_i[3:2]), .dat_i(wb_dat_i),
    .dat_o(s_dat[SLV_SYSCTL]), .ack_o(s_ack[SLV_SYSCTL]),
    .heartbeat_o(heartbeat_o)
  );

  // ----------------------------------------------------------
  // Pin split, hex0 in the lowest group
  assign hex0_o = disp_pins[6:0];
  assign hex1_o = disp_pins[13:7];
  assign hex2_o = disp_pins[20:14];
  assign hex3_o = disp_pins[27:21];
  assign ledg_o = led_pins[7:0];
  assign ledr_o = led_pins[17:8];

endmodule

`default_nettype wire

// ==== qaz_properties.sv ====
// ----------------------------------------------------------
// Host port handshake checks
// Bound to qaz_top, shape of ack and err
// ----------------------------------------------------------
`default_nettype none

module qaz_properties (
  input logic sys_clk,
  input logic sys_rst,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic err_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Only one response per transfer
  a_ack_err_excl: assert property (@(posedge sys_clk) disable iff (sys_rst)
    !(ack_i && err_i))
    else $error("ack and err high in the same cycle");

  a_ack_one: assert property (@(posedge sys_clk) disable iff (sys_rst)
    ack_i |=> !ack_i)
    else $error("ack held for more than one cycle");

  a_err_one: assert property (@(posedge sys_clk) disable iff (sys_rst)
    err_i |=> !err_i)
    else $error("err held for more than one cycle");

  // Response follows a sampled strobe
  a_resp_needs_stb: assert property (@(posedge sys_clk) disable iff (sys_rst)
    ($rose(ack_i) || $rose(err_i)) |-> $past(cyc_i && stb_i))
    else $error("response without a host strobe");

endmodule

bind qaz_top qaz_properties u_props (
  .sys_clk(sys_clk), .sys_rst(sys_rst), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
  .ack_i(wb_ack_o), .err_i(wb_err_o)
);

`default_nettype wire

// ==== qaz_tb.sv ====
// ----------------------------------------------------------
// QAZ bus core testbench
// Table-driven host accesses, pin stimulus and irq checks
// ----------------------------------------------------------
`default_nettype none

module qaz_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import qaz_pkg::*;

  localparam logic [2:0] OP_WR  = 3'd0;  // Host write
  localparam logic [2:0] OP_RD  = 3'd1;  // Host read and compare
  localparam logic [2:0] OP_KEY = 3'd2;  // Drive keys, then settle
  localparam logic [2:0] OP_SW  = 3'd3;  // Drive switches, then settle
  localparam logic [2:0] OP_INT = 3'd4;  // Compare int_o level
  localparam logic [2:0] OP_CYC = 3'd5;  // Two counter reads, compare delta

  typedef struct packed {
    logic [2:0] op;
    addr_t      adr;
    data_t      wd;   // Write data or pin value
    data_t      exp;  // Read data, int level or counter delta
    logic       err;
  } step_t;

  logic       sys_clk;
  logic       sys_rst;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  addr_t      wb_adr;
  data_t      wb_dat_w;
  data_t      wb_dat_r;
  logic       wb_ack;
  logic       wb_err;
  logic [3:0] key;
  logic [9:0] sw;
  seg_t       hex [4];
  logic [7:0] ledg;
  logic [9:0] ledr;
  logic       int_line;
  logic       heartbeat;

  step_t       tbl [$];
  logic [31:0] lfsr_q;
  logic        tbl_ready;

  qaz_top #(.HB_BIT(4)) DUT (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
    .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
    .wb_ack_o(wb_ack), .wb_err_o(wb_err), .key_i(key), .sw_i(sw),
    .hex0_o(hex[0]), .hex1_o(hex[1]), .hex2_o(hex[2]), .hex3_o(hex[3]),
    .ledg_o(ledg), .ledr_o(ledr), .int_o(int_line), .heartbeat_o(heartbeat)
  );

  initial
  begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;  // 8 ns period
  end

  // ----------------------------------------------------------
  // Helpers
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input data_t got, input data_t exp, input string what);
    if (got !== exp)
    begin
      $display("** Error @ %0t ns: %s, got %h expected %h", $time, what, got, exp);
      abort_run("Check mismatch");
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic addr_t reg_adr(input logic [3:0] sel, input reg_off_t off);
    return {sel, 16'h0000, off, 2'b00};  // Select in 23:20, word offset in 3:2
  endfunction

  function automatic void add_step(input logic [2:0] op, input addr_t adr,
                                   input data_t wd, input data_t exp, input logic err);
    step_t s;
    s.op  = op;
    s.adr = adr;
    s.wd  = wd;
    s.exp = exp;
    s.err = err;
    tbl.push_back(s);
  endfunction

  // One Wishbone classic access, held until ack or err
  task automatic bus_xfer(input logic we, input addr_t adr, input data_t wd,
                          output data_t rd, output logic ack, output logic err);
    @(posedge sys_clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wd;
    do
    begin
      @(posedge sys_clk);
      #1;
    end while (!(wb_ack || wb_err));
    rd     = wb_dat_r;
    ack    = wb_ack;
    err    = wb_err;
    wb_cyc = 1'b0;  // Strobe low for at least one edge
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Stimulus table
  task automatic build_table();
    data_t w0;
    data_t w1;
    data_t sw0;
    data_t key0;
    w0   = take_bits(32);
    w1   = take_bits(32);
    sw0  = take_bits(10);
    key0 = take_bits(4);
    // ID and scratch
    add_step(OP_RD, reg_adr(SLV_SYSCTL, SYS_ID), '0, SYS_ID_VALUE, 1'b0);
    add_step(OP_WR, reg_adr(SLV_SYSCTL, SYS_SCRATCH), w0, '0, 1'b0);
    add_step(OP_RD, reg_adr(SLV_SYSCTL, SYS_SCRATCH), '0, w0, 1'b0);
    add_step(OP_WR, reg_adr(SLV_SYSCTL, SYS_SCRATCH), w1, '0, 1'b0);
    add_step(OP_RD, reg_adr(SLV_SYSCTL, SYS_SCRATCH), '0, w1, 1'b0);
    // Unmapped selects 0 and 7, then a mapped access
    add_step(OP_WR, reg_adr(4'd0, 2'd0), 32'hdead_beef, '0, 1'b1);
    add_step(OP_RD, reg_adr(4'd7, 2'd1), '0, '0, 1'b1);
    add_step(OP_RD, reg_adr(4'd0, 2'd3), '0, '0, 1'b1);
    add_step(OP_RD, reg_adr(SLV_SYSCTL, SYS_SCRATCH), '0, w1, 1'b0);
    // Output registers, upper bits read zero
    add_step(OP_WR, reg_adr(SLV_GPIO_A, GPIO_OUT), 32'hfabc_de12, '0, 1'b0);
    add_step(OP_RD, reg_adr(SLV_GPIO_A, GPIO_OUT), '0, 32'hfabc_de12 & 32'h0fff_ffff, 1'b0);
    add_step(OP_WR, reg_adr(SLV_GPIO_B, GPIO_OUT), 32'habc5_5aa5, '0, 1'b0);
    add_step(OP_RD, reg_adr(SLV_GPIO_B, GPIO_OUT), '0, 32'habc5_5aa5 & 32'h0003_ffff, 1'b0);
    // Random pins into GPIO_IN
    add_step(OP_SW, '0, sw0, '0, 1'b0);
    add_step(OP_RD, reg_adr(SLV_GPIO_B, GPIO_IN), '0, sw0, 1'b0);
    add_step(OP_KEY, '0, key0, '0, 1'b0);
    add_step(OP_RD, reg_adr(SLV_GPIO_A, GPIO_IN), '0, key0, 1'b0);
    // Interrupt path on switch bit 0
    add_step(OP_SW, '0, '0, '0, 1'b0);
    add_step(OP_WR, reg_adr(SLV_GPIO_B, GPIO_IS), 32'h0000_03ff, '0, 1'b0);
    add_step(OP_WR, reg_adr(SLV_GPIO_B, GPIO_IE), 32'h0000_0001, '0, 1'b0);
    add_step(OP_WR, reg_adr(SLV_PIC, PIC_MASK), 32'h0000_0001, '0, 1'b0);
    add_step(OP_INT, '0, '0, 32'd0, 1'b0);
    add_step(OP_SW, '0, 32'h0000_0001, '0, 1'b0);
    add_step(OP_INT, '0, '0, 32'd1, 1'b0);
    add_step(OP_RD, reg_adr(SLV_GPIO_B, GPIO_IS), '0, 32'h0000_0001, 1'b0);
    add_step(OP_RD, reg_adr(SLV_PIC, PIC_PEND), '0, 32'h0000_0001, 1'b0);
    add_step(OP_WR, reg_adr(SLV_GPIO_B, GPIO_IS), 32'h0000_0001, '0, 1'b0);
    add_step(OP_INT, '0, '0, 32'd0, 1'b0);
    add_step(OP_RD, reg_adr(SLV_GPIO_B, GPIO_IS), '0, '0, 1'b0);
    add_step(OP_WR, reg_adr(SLV_PIC, PIC_MASK), '0, '0, 1'b0);
    add_step(OP_SW, '0, '0, '0, 1'b0);
    add_step(OP_SW, '0, 32'h0000_0001, '0, 1'b0);
    add_step(OP_RD, reg_adr(SLV_GPIO_B, GPIO_IS), '0, 32'h0000_0001, 1'b0);
    add_step(OP_INT, '0, '0, 32'd0, 1'b0);  // Masked
    add_step(OP_RD, reg_adr(SLV_PIC, PIC_PEND), '0, 32'h0000_0001, 1'b0);
    // Ack edges two cycles apart, one-cycle ack plus one idle
    // Sixteen reads span both heartbeat levels
    for (int i = 0; i < 8; i++)
      add_step(OP_CYC, reg_adr(SLV_SYSCTL, SYS_CYCLES), '0, 32'd2, 1'b0);
  endtask

  task automatic apply_step(input step_t s);
    data_t rd;
    data_t c1;
    logic  ack;
    logic  err;
    logic  hb1;
    case (s.op)
      OP_WR, OP_RD:
      begin
        bus_xfer(s.op == OP_WR, s.adr, s.wd, rd, ack, err);
        check_eq({31'd0, err}, {31'd0, s.err}, "err response");
        check_eq({31'd0, ack}, {31'd0, ~s.err}, "ack response");
        if (s.op == OP_RD)
          check_eq(rd, s.exp, "read data");
        else if (!s.err && s.adr[3:2] == GPIO_OUT)
        begin
          @(posedge sys_clk);  // Edge after ack
          #1;
          if (s.adr[23:20] == SLV_GPIO_A)
            check_eq({4'd0, hex[3], hex[2], hex[1], hex[0]}, {4'd0, s.wd[27:0]}, "hex digits");
          if (s.adr[23:20] == SLV_GPIO_B)
            check_eq({14'd0, ledr, ledg}, {14'd0, s.wd[17:0]}, "leds");
        end
      end
      OP_KEY, OP_SW:
      begin
        @(posedge sys_clk);
        #1;
        if (s.op == OP_KEY)
          key = s.wd[3:0];
        else
          sw = s.wd[9:0];
        repeat (6) @(posedge sys_clk);  // Sync and irq latency margin
      end
      OP_INT:
      begin
        @(posedge sys_clk);
        #1;
        check_eq({31'd0, int_line}, s.exp, "int_o level");
      end
      default:
      begin
        bus_xfer(1'b0, s.adr, '0, c1, ack, err);
        hb1 = heartbeat;
        bus_xfer(1'b0, s.adr, '0, rd, ack, err);
        check_eq(rd - c1, s.exp, "cycle counter delta");
        check_eq({31'd0, hb1}, {31'd0, c1[4]}, "heartbeat, first read");
        check_eq({31'd0, heartbeat}, {31'd0, rd[4]}, "heartbeat, second read");
      end
    endcase
  endtask

  // ----------------------------------------------------------
  // Main sequence
  initial
  begin
    sys_rst   = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    key       = '0;
    sw        = '0;
    lfsr_q    = 32'h9c8d;
    tbl_ready = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (8) @(posedge sys_clk);
    #1;
    sys_rst = 1'b0;
    check_eq({4'd0, hex[3], hex[2], hex[1], hex[0]}, '0, "display after reset");
    check_eq({14'd0, ledr, ledg}, '0, "leds after reset");
    check_eq({31'd0, int_line}, '0, "int_o after reset");
    foreach (tbl[i])
      apply_step(tbl[i]);
    $display("Simulation finished: PASS");
    $finish;
  end

  // Watchdog, 20 cycles per table entry
  initial
  begin
    wait (tbl_ready);
    repeat (tbl.size() * 20) @(posedge sys_clk);
    abort_run("Timeout: the table did not complete in the allowed cycles");
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
qaz_pkg.sv
wb_slave_decode.sv
gpio_port.sv
qaz_pic.sv
qaz_sysctl.sv
qaz_top.sv
qaz_properties.sv
qaz_tb.sv

// ==== Makefile ====
# Verilator build and run of the QAZ bus core testbench

VERILATOR ?= verilator
TOP       ?= qaz_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
